//--- tests/videoPatterns.txt
// Line A: flip, then x y colour of objects 0 to 3
// Line B: h v expected colour of probes 0 to 3, all values hex bytes
// Case 0, single objects and a colour 0 object
00 0A 0A 03 28 14 05 3C 1E 00 64 50 09
0C 0C 03 2D 19 05 3E 21 00 6B 57 09
// Case 1, overlapping objects
00 14 14 01 18 18 02 1A 14 07 14 1E 0F
19 19 01 1E 16 07 1D 19 02 17 1F 0F
// Case 2, hidden duplicate, screen corners, just outside an edge
00 32 28 04 32 28 06 78 58 0A 00 00 02
39 2F 04 3A 2F 00 7F 5F 0A 00 00 02
// Case 3, flipped screen, objects in flipped coordinates
01 90 C0 0B F0 F0 0C 94 C4 0D 10 10 0E
92 C2 0B 9A C6 0D F7 F7 0C A0 A0 00

//--- tb.f
common/videoPkg.sv
rtl/timingProm.sv
timing/videoTiming.sv
rtl/objectMatch.sv
rtl/pixelMixer.sv
rtl/videoTop.sv
tests/videoTb_assertions.sv
tests/videoTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module videoTb -o videoSim

simOut="$(./obj_dir/videoSim)"
echo "$simOut"

if grep -qx "all tests passed" <<< "$simOut"; then
    exit 0
fi
exit 1

//--- tests/videoTb.sv
////////////////////
// Video testbench
// Timing, object priority and flip from a pattern file
////////////////////

`timescale 1ns/1ps

module videoTb;
    import videoPkg::*;

    localparam int NumObj     = 4;
    localparam int HTotal     = 192;
    localparam int HActive    = 128;
    localparam int VActive    = 96;
    localparam int SelW       = (NumObj > 1) ? $clog2(NumObj) : 1;
    localparam int ProbeCnt   = 4;                 // Probes per case
    localparam int CaseCnt    = 4;
    localparam int CaseWords  = 1 + 3 * NumObj + 3 * ProbeCnt;
    localparam int GroupW     = 8;                 // Pixels per hbdN group
    localparam int FrameLimit = 2 * 256 * HTotal;  // Two frames of pixels

    logic            clk;
    logic            rstN;
    logic            pxlCen;
    logic            flipN;
    promAddrT        promAddr;
    logic            promWe;
    promDataT        promDin;
    logic            objWe;
    logic [SelW-1:0] objSel;
    coordT           objX;
    coordT           objY;
    colorT           objColor;
    coordT           h;
    coordT           v;
    logic            hb;
    logic            hbdN;
    logic            vb;
    colorT           pixColor;
    coordT           pixH;
    coordT           pixV;
    logic            pixBlank;

    logic [7:0] patterns [CaseCnt * CaseWords]; // Raw bytes of the pattern file
    coordT      modelX [NumObj];                // Objects of the current case
    coordT      modelY [NumObj];
    colorT      modelC [NumObj];
    int         errors;
    int         errorsAtStart;
    int         testCnt;
    int         failCnt;

    videoTop #(
        .NumObj  (NumObj),
        .HTotal  (HTotal),
        .HActive (HActive),
        .VActive (VActive)
    ) u_videoTop (
        .clk      (clk),
        .rstN     (rstN),
        .pxlCen   (pxlCen),
        .flipN    (flipN),
        .promAddr (promAddr),
        .promWe   (promWe),
        .promDin  (promDin),
        .objWe    (objWe),
        .objSel   (objSel),
        .objX     (objX),
        .objY     (objY),
        .objColor (objColor),
        .h        (h),
        .v        (v),
        .hb       (hb),
        .hbdN     (hbdN),
        .vb       (vb),
        .pixColor (pixColor),
        .pixH     (pixH),
        .pixV     (pixV),
        .pixBlank (pixBlank)
    );

    bind videoTop videoTbAssertions u_videoTbAssertions (
        .clk      (clk),
        .rstN     (rstN),
        .pxlCen   (pxlCen),
        .flipN    (flipN),
        .h        (h),
        .hb       (hb),
        .hbdN     (hbdN),
        .pixBlank (pixBlank),
        .pixColor (pixColor)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // Pixel strobe on every fourth clk
    initial begin
        int phase;
        phase  = 0;
        pxlCen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            pxlCen = (phase == 3);
            phase  = (phase + 1) % 4;
        end
    end

    task automatic checkColor(input colorT got, input colorT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic checkCoord(input coordT got, input coordT exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic timeoutStop(input string what);
        $display("Timeout while waiting for %s, the beam did not get there", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic finishTest(input string name);
        testCnt++;
        if (errors == errorsAtStart) begin
            $display("Test %s: ok", name);
        end else begin
            failCnt++;
            $display("Test %s: %0d errors", name, errors - errorsAtStart);
        end
        errorsAtStart = errors;
    endtask

    // Next negedge with a strobe pending, the presented pixel is stable here
    task automatic waitPixel();
        int n;
        n = 0;
        @(negedge clk);
        while (!pxlCen) begin
            n++;
            if (n > 8) timeoutStop("a pixel strobe");
            @(negedge clk);
        end
        if (pixBlank) checkColor(pixColor, '0, "colour during blank");
    endtask

    task automatic waitLineStart();
        int n;
        n = 0;
        waitPixel();
        while (h !== '0) begin
            n++;
            if (n > HTotal + 8) timeoutStop("the start of a line");
            waitPixel();
        end
    endtask

    task automatic waitHV(input coordT hT, input coordT vT);
        int n;
        n = 0;
        waitPixel();
        while (h !== hT || v !== vT) begin
            n++;
            if (n > FrameLimit) timeoutStop("a beam position");
            waitPixel();
        end
    endtask

    // Output pixel tagged with the probe position
    task automatic waitProbe(input coordT ph, input coordT pv);
        int n;
        n = 0;
        waitPixel();
        while (pixH !== ph || pixV !== pv) begin
            n++;
            if (n > FrameLimit) timeoutStop("a probed output pixel");
            waitPixel();
        end
    endtask

    task automatic writeProm(input promAddrT addr, input promDataT data);
        @(posedge clk);
        #1;
        promWe   = 1'b1;
        promAddr = addr;
        promDin  = data;
        @(posedge clk);
        #1;
        promWe = 1'b0;
    endtask

    task automatic loadObject(input int idx, input coordT x, input coordT y, input colorT c);
        @(posedge clk);
        #1;
        objWe    = 1'b1;
        objSel   = SelW'(idx);
        objX     = x;
        objY     = y;
        objColor = c;
        @(posedge clk);
        #1;
        objWe = 1'b0;
    endtask

    // Lowest index covering object wins, colour 0 never covers
    function automatic colorT modelColor(input coordT ph, input coordT pv);
        colorT result;
        bit    found;
        result = '0;
        found  = 1'b0;
        for (int i = 0; i < NumObj; i++) begin
            if (!found && modelC[i] != '0 &&
                int'(ph) >= int'(modelX[i]) && int'(ph) < int'(modelX[i]) + objSize &&
                int'(pv) >= int'(modelY[i]) && int'(pv) < int'(modelY[i]) + objSize) begin
                result = modelC[i];
                found  = 1'b1;
            end
        end
        return result;
    endfunction

    task automatic checkFirstLine();
        int n;
        bit sawLast;
        n       = 0;
        sawLast = 1'b0;
        waitPixel();
        while (!hb) begin
            if (h == coordT'(HActive - 1)) sawLast = 1'b1;
            n++;
            if (n > HTotal + 8) timeoutStop("the first horizontal blank");
            waitPixel();
        end
        checkFlag(sawLast, 1'b1, "last visible h seen before hb");
        checkCoord(h, coordT'(HActive), "h at hb rise");
    endtask

    task automatic checkLineTiming();
        int    hbCnt;
        int    hbdCnt;
        int    pixBlankCnt;
        int    pExp;
        coordT vStart;
        coordT vExp;
        hbCnt       = 0;
        hbdCnt      = 0;
        pixBlankCnt = 0;
        waitLineStart();
        vStart = v;
        for (int n = 0; n < HTotal; n++) begin
            pExp = (n + HTotal - 2) % HTotal; // Output lags the beam by two strobes
            vExp = (n > HActive + 2) ? vStart + 1'b1 : vStart; // Line steps after h HActive
            checkCoord(pixH, coordT'(pExp), "pixH behind the beam");
            checkCoord(pixV, vExp, "pixV behind the beam");
            if (hb) hbCnt++;
            if (!hbdN) hbdCnt++;
            if (pixBlank) pixBlankCnt++;
            waitPixel();
        end
        checkCoord(h, '0, "h one line later");
        checkCoord(v, vStart + 1'b1, "v one line later");
        checkCoord(coordT'(hbCnt), coordT'(HTotal - HActive), "hb pixels per line");
        checkCoord(coordT'(hbdCnt), coordT'(HTotal - HActive - GroupW), "hbdN low pixels");
        checkCoord(coordT'(pixBlankCnt), coordT'(HTotal - HActive), "pixBlank pixels per line");
    endtask

    task automatic checkVerticalBlank();
        waitHV('0, coordT'(VActive - 1));
        checkFlag(vb, 1'b0, "vb on last visible line");
        waitHV('0, coordT'(VActive));
        checkFlag(vb, 1'b1, "vb on first blank line");
    endtask

    task automatic runPattern(input int c);
        int    base;
        int    pBase;
        coordT ph;
        coordT pv;
        colorT pe;
        base = c * CaseWords;
        @(posedge clk);
        #1;
        flipN = ~patterns[base][0];
        for (int i = 0; i < NumObj; i++) begin
            modelX[i] = patterns[base + 1 + 3 * i];
            modelY[i] = patterns[base + 2 + 3 * i];
            modelC[i] = colorT'(patterns[base + 3 + 3 * i]);
            loadObject(i, modelX[i], modelY[i], modelC[i]);
        end
        repeat (4) waitPixel(); // Drain the two stage pipeline
        for (int p = 0; p < ProbeCnt; p++) begin
            pBase = base + 1 + 3 * NumObj + 3 * p;
            ph    = patterns[pBase];
            pv    = patterns[pBase + 1];
            pe    = colorT'(patterns[pBase + 2]);
            if (modelColor(ph, pv) !== pe) begin
                errors++;
                $display("Pattern case %0d probe %0d: file says %0h but priority model says %0h",
                         c, p, pe, modelColor(ph, pv));
            end
            waitProbe(ph, pv);
            checkColor(pixColor, pe, $sformatf("colour at h %0d v %0d", ph, pv));
            checkFlag(pixBlank, 1'b0, $sformatf("blank at h %0d v %0d", ph, pv));
        end
    endtask

    // Same raw count seen plain, then flipped, between two strobes
    task automatic checkFlipOutputs();
        coordT hPlain;
        coordT vPlain;
        @(posedge clk);
        #1;
        flipN = 1'b1;
        repeat (3) begin
            waitPixel();
            @(posedge clk);   // Counters step here
            @(negedge clk);
            hPlain = h;
            vPlain = v;
            @(posedge clk);   // No strobe on this edge
            #1;
            flipN = 1'b0;
            @(negedge clk);
            checkCoord(h, {~hPlain[7:3], hPlain[2:0]}, "flipped h");
            checkCoord(v, ~vPlain, "flipped v");
            @(posedge clk);
            #1;
            flipN = 1'b1;
        end
    endtask

    initial begin
        rstN          = 1'b0;
        flipN         = 1'b1;
        promAddr      = '0;
        promWe        = 1'b0;
        promDin       = '0;
        objWe         = 1'b0;
        objSel        = '0;
        objX          = '0;
        objY          = '0;
        objColor      = '0;
        errors        = 0;
        errorsAtStart = 0;
        testCnt       = 0;
        failCnt       = 0;
        $readmemh("tests/videoPatterns.txt", patterns);

        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkCoord(h, '0, "h after reset");
        checkCoord(v, '0, "v after reset");
        checkFlag(hb, 1'b0, "hb after reset");
        checkFlag(vb, 1'b0, "vb after reset");
        checkFlag(hbdN, 1'b1, "hbdN after reset");
        checkFlag(pixBlank, 1'b0, "pixBlank after reset");
        checkColor(pixColor, '0, "pixColor after reset");

        // Line step at the first blank pixel pair, {hb, h[7:1]}
        writeProm({1'b1, 7'(HActive >> 1)}, 4'b0010);

        checkFirstLine();
        finishTest("reset and first line");
        checkLineTiming();
        finishTest("line timing");
        checkVerticalBlank();
        finishTest("vertical blank");
        for (int c = 0; c < CaseCnt; c++) begin
            runPattern(c);
            finishTest($sformatf("pattern %0d", c));
        end
        checkFlipOutputs();
        finishTest("flip");

        $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
                 testCnt, failCnt, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- tests/videoTb_assertions.sv
////////////////////
// Video output checks
// Blanking, delayed blank and pixel-rate h
////////////////////

`timescale 1ns/1ps

module videoTbAssertions (
    input logic            clk,
    input logic            rstN,
    input logic            pxlCen,
    input logic            flipN,
    input videoPkg::coordT h,
    input logic            hb,
    input logic            hbdN,
    input logic            pixBlank,
    input videoPkg::colorT pixColor
);

    // Blanked pixels are black
    blankBlack: assert property (@(posedge clk) disable iff (!rstN)
        pixBlank |-> pixColor == '0)
        else $error("pixel colour nonzero while pixBlank is high");

    // Delayed blank only inside hb, falling on a group boundary
    hbdInsideHb: assert property (@(posedge clk) disable iff (!rstN)
        !hbdN |-> hb && (!$fell(hbdN) || h[2:0] == 3'd0))
        else $error("hbdN low outside horizontal blank or off a group boundary");

    // h moves on a pixel strobe, or when flip changes
    hPixelRate: assert property (@(posedge clk) disable iff (!rstN)
        !$stable(h) |-> $past(pxlCen) || !$stable(flipN))
        else $error("h changed without a pixel strobe");

endmodule

//--- rtl/videoTop.sv
////////////////////
// Video top level
// Timing, object matcher bank and mixer
////////////////////

`timescale 1ns/1ps

module videoTop #(
    parameter int NumObj  = 4,
    parameter int HTotal  = 192,
    parameter int HActive = 128,
    parameter int VActive = 96,
    localparam int SelW   = (NumObj > 1) ? $clog2(NumObj) : 1
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               pxlCen,
    input  logic               flipN,
    input  videoPkg::promAddrT promAddr,  // PROM programming
    input  logic               promWe,
    input  videoPkg::promDataT promDin,
    input  logic               objWe,     // Object load
    input  logic [SelW-1:0]    objSel,
    input  videoPkg::coordT    objX,
    input  videoPkg::coordT    objY,
    input  videoPkg::colorT    objColor,
    output videoPkg::coordT    h,
    output videoPkg::coordT    v,
    output logic               hb,
    output logic               hbdN,
    output logic               vb,
    output videoPkg::colorT    pixColor,
    output videoPkg::coordT    pixH,
    output videoPkg::coordT    pixV,
    output logic               pixBlank
);
    import videoPkg::*;

    logic [NumObj-1:0]        objWeVec; // Decoded load strobes
    logic [NumObj-1:0]        hitVec;
    logic [NumObj*colorW-1:0] colorVec;
    logic                     blank;

    videoTiming #(
        .HTotal  (HTotal),
        .HActive (HActive),
        .VActive (VActive)
    ) u_videoTiming (
        .clk        (clk),
        .rstN       (rstN),
        .pxlCen     (pxlCen),
        .flipN      (flipN),
        .promWe     (promWe),
        .promWrAddr (promAddr),
        .promDin    (promDin),
        .h          (h),
        .v          (v),
        .hb         (hb),
        .hbdN       (hbdN),
        .vb         (vb)
    );

    assign blank = hb | vb;

    for (genvar i = 0; i < NumObj; i++) begin : gObj
        assign objWeVec[i] = objWe && (objSel == SelW'(i));

        objectMatch u_objectMatch (
            .clk      (clk),
            .rstN     (rstN),
            .pxlCen   (pxlCen),
            .we       (objWeVec[i]),
            .x        (objX),
            .y        (objY),
            .color    (objColor),
            .h        (h),
            .v        (v),
            .hit      (hitVec[i]),
            .hitColor (colorVec[i*colorW +: colorW])
        );
    end

    pixelMixer #(
        .NumObj (NumObj)
    ) u_pixelMixer (
        .clk      (clk),
        .rstN     (rstN),
        .pxlCen   (pxlCen),
        .hitVec   (hitVec),
        .colorVec (colorVec),
        .h        (h),
        .v        (v),
        .blank    (blank),
        .pixColor (pixColor),
        .pixH     (pixH),
        .pixV     (pixV),
        .pixBlank (pixBlank)
    );

endmodule

//--- rtl/pixelMixer.sv
////////////////////
// Pixel mixer
// Lowest index hit wins, blanking, output register
////////////////////

`timescale 1ns/1ps

module pixelMixer #(
    parameter int NumObj = 4
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               pxlCen,
    input  logic [NumObj-1:0]                  hitVec,   // One bit per matcher
    input  logic [NumObj*videoPkg::colorW-1:0] colorVec,
    input  videoPkg::coordT                    h,
    input  videoPkg::coordT                    v,
    input  logic                               blank,
    output videoPkg::colorT                    pixColor,
    output videoPkg::coordT                    pixH,     // Beam position of pixColor
    output videoPkg::coordT                    pixV,
    output logic                               pixBlank
);
    import videoPkg::*;

    coordT hD;        // Beam delayed to match the matchers
    coordT vD;
    logic  blankD;
    colorT selColor;

    // Priority select, index 0 highest
    always_comb begin
        selColor = '0;
        for (int i = NumObj - 1; i >= 0; i--) begin
            if (hitVec[i]) selColor = colorVec[i*colorW +: colorW];
        end
    end

    always_ff @(posedge clk) begin
        if (pxlCen) begin
            hD   <= h;
            vD   <= v;
            pixH <= hD;
            pixV <= vD;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            blankD   <= 1'b0;
            pixBlank <= 1'b0;
            pixColor <= '0;
        end else if (pxlCen) begin
            blankD   <= blank;
            pixBlank <= blankD;
            pixColor <= blankD ? '0 : selColor; // Black during blank
        end
    end

endmodule

//--- rtl/objectMatch.sv
////////////////////
// Object matcher
// One 8x8 solid object, hit test against beam
////////////////////

`timescale 1ns/1ps

module objectMatch (
    input  logic            clk,
    input  logic            rstN,
    input  logic            pxlCen,
    input  logic            we,        // Load position and colour
    input  videoPkg::coordT x,
    input  videoPkg::coordT y,
    input  videoPkg::colorT color,
    input  videoPkg::coordT h,         // Beam, already flipped
    input  videoPkg::coordT v,
    output logic            hit,       // Valid one strobe after the beam
    output videoPkg::colorT hitColor
);
    import videoPkg::*;

    coordT xReg;     // Top left corner
    coordT yReg;
    colorT colorReg; // 0 disables the object
    coordT dx;
    coordT dy;
    logic  inX;
    logic  inY;

    // Object registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            colorReg <= '0;
        end else if (we) begin
            colorReg <= color;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            xReg <= x;
            yReg <= y;
        end
    end

    // Offsets into the square, no wrap past the screen edge
    assign dx  = h - xReg;
    assign dy  = v - yReg;
    assign inX = (h >= xReg) && (dx < coordT'(objSize));
    assign inY = (v >= yReg) && (dy < coordT'(objSize));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hit      <= 1'b0;
            hitColor <= '0;
        end else if (pxlCen) begin
            hit      <= inX && inY && (colorReg != '0);
            hitColor <= colorReg;
        end
    end

endmodule

//--- timing/videoTiming.sv
////////////////////
// Video timing generator
// H/V counters, blanking, flip, PROM line step
////////////////////

`timescale 1ns/1ps

module videoTiming #(
    parameter int HTotal  = 192, // Pixel enables per line
    parameter int HActive = 128, // Visible pixels
    parameter int VActive = 96   // Visible lines
) (
    input  logic               clk,
    input  logic               rstN,
    input  logic               pxlCen,     // One strobe per pixel
    input  logic               flipN,      // Low flips the screen
    input  logic               promWe,
    input  videoPkg::promAddrT promWrAddr,
    input  videoPkg::promDataT promDin,
    output videoPkg::coordT    h,
    output videoPkg::coordT    v,
    output logic               hb,
    output logic               hbdN,       // Low once hb is a full group old
    output logic               vb
);
    import videoPkg::*;

    coordT    hCnt;       // Raw counts, never flipped
    coordT    vCnt;
    logic     flip;
    logic     hbLatch;    // hb seen at end of an 8 pixel group
    logic     vupL;       // Previous PROM bit 1
    logic     vupEdge;
    promAddrT promRdAddr;
    promDataT promRdData;

    assign flip = ~flipN;

    // Horizontal counter
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCnt <= '0;
        end else if (pxlCen) begin
            if (int'(hCnt) == HTotal - 1) begin
                hCnt <= '0; // End of line
            end else begin
                hCnt <= hCnt + 1'b1;
            end
        end
    end

    assign hb = int'(hCnt) >= HActive;

    // Delayed blank
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hbLatch <= 1'b0;
        end else if (pxlCen) begin
            if (!hb) begin
                hbLatch <= 1'b0;
            end else if (&hCnt[2:0]) begin
                hbLatch <= 1'b1; // Whole group spent in blank
            end
        end
    end

    assign hbdN = ~(hbLatch & hb); // Drops with hb at line wrap

    // PROM lookup, data follows one clk later
    assign promRdAddr = {hb, hCnt[coordW-1:1]};

    timingProm u_timingProm (
        .clk    (clk),
        .rstN   (rstN),
        .we     (promWe),
        .wrAddr (promWrAddr),
        .din    (promDin),
        .rdAddr (promRdAddr),
        .q      (promRdData)
    );

    // Line counter steps on rising PROM bit 1
    assign vupEdge = promRdData[1] & ~vupL;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            vupL <= 1'b0;
            vCnt <= '0;
        end else if (pxlCen) begin
            vupL <= promRdData[1];
            if (vupEdge) vCnt <= vCnt + 1'b1; // Wraps at 256
        end
    end

    assign vb = int'(vCnt) >= VActive;

    // Flip leaves the pixel-within-group bits alone
    assign h = {hCnt[coordW-1:3] ^ {(coordW-3){flip}}, hCnt[2:0]};
    assign v = vCnt ^ {coordW{flip}};

endmodule

//--- rtl/timingProm.sv
////////////////////
// Timing PROM
// 256 x 4 with write port and registered read
////////////////////

`timescale 1ns/1ps

module timingProm (
    input  logic               clk,
    input  logic               rstN,
    input  logic               we,     // Programming strobe
    input  videoPkg::promAddrT wrAddr,
    input  videoPkg::promDataT din,
    input  videoPkg::promAddrT rdAddr,
    output videoPkg::promDataT q       // One clk after rdAddr
);
    import videoPkg::*;

    promDataT mem [2**promAddrW]; // Per-line timing pattern

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 2**promAddrW; i++) begin
                mem[i] <= '0; // Blank pattern, no vertical steps
            end
            q <= '0;
        end else begin
            if (we) mem[wrAddr] <= din;
            q <= mem[rdAddr];
        end
    end

endmodule

//--- common/videoPkg.sv
////////////////////
// Video shared definitions
// Beam coordinates, colours and timing PROM words
////////////////////

package videoPkg;

    // Beam and object coordinates
    localparam int coordW = 8;
    typedef logic [coordW-1:0] coordT;

    // Pixel colour index
    localparam int colorW = 4;         // 16 colours
    typedef logic [colorW-1:0] colorT; // 0 is background or transparent

    // Timing PROM, 256 x 4
    localparam int promAddrW = 8;
    localparam int promDataW = 4;
    typedef logic [promAddrW-1:0] promAddrT; // {hb, h[7:1]}
    typedef logic [promDataW-1:0] promDataT; // Bit 1 steps the line counter

    // Object footprint
    localparam int objSize = 8; // Square, in pixels

endpackage
